// File: bench/core_out_assert.sv
/*
 * concurrent checks on the adapter outputs, bound to the top level
 * the lrck spacing check starts after the first toggle seen
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_out_config.svh"

module core_out_assert (
    input logic clk_12_288_mhz,
    input logic reset,
    input logic [$bits(core_out_pkg::rgb_word_u)-1:0] video_rgb,
    input logic video_de,
    input logic video_skip,
    input logic video_hs,
    input logic video_vs,
    input logic audio_lrck
);

    localparam int half_frame = `CORE_OUT_I2S_SLOT_BITS * `CORE_OUT_I2S_BIT_CYCLES;

    logic lrck_q;
    logic seen_toggle;
    logic [7:0] since_toggle;
    logic lrck_changed;

    assign lrck_changed = audio_lrck != lrck_q;

    // cycles since the last lrck change, saturating
    always_ff @(posedge clk_12_288_mhz) begin
        if (reset) begin
            lrck_q       <= 1'b0;
            seen_toggle  <= 1'b0;
            since_toggle <= '0;
        end else begin
            lrck_q <= audio_lrck;
            if (lrck_changed) begin
                seen_toggle  <= 1'b1;
                since_toggle <= 8'd1;
            end else if (since_toggle != 8'hff) begin
                since_toggle <= since_toggle + 8'd1;
            end
        end
    end

    hs_single: assert property (@(posedge clk_12_288_mhz) disable iff (reset)
        video_hs |=> !video_hs) else $error("video_hs stayed high for two cycles");

    vs_single: assert property (@(posedge clk_12_288_mhz) disable iff (reset)
        video_vs |=> !video_vs) else $error("video_vs stayed high for two cycles");

    skip_in_de: assert property (@(posedge clk_12_288_mhz) disable iff (reset)
        video_skip |-> video_de) else $error("video_skip high outside data enable");

    rgb_blanked: assert property (@(posedge clk_12_288_mhz) disable iff (reset)
        !video_de |-> video_rgb == '0) else $error("video_rgb not zero while blanked");

    lrck_period: assert property (@(posedge clk_12_288_mhz) disable iff (reset)
        (lrck_changed && seen_toggle) |-> since_toggle == 8'(half_frame))
        else $error("audio_lrck changed off the half-frame spacing");

endmodule

bind core_out_top core_out_assert u_assert (
    .clk_12_288_mhz (clk_12_288_mhz),
    .reset          (reset),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_skip     (video_skip),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .audio_lrck     (audio_lrck)
);

`default_nettype wire

// File: bench/core_out_tb.sv
/*
 * directed testbench for the core output adapter
 * inputs change on the falling clock edge, outputs are sampled there too
 * the first error stops the run, a watchdog bounds the total time
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_out_config.svh"

module core_out_tb;

    import core_out_pkg::*;

    localparam int half_frame = `CORE_OUT_I2S_SLOT_BITS * `CORE_OUT_I2S_BIT_CYCLES;
    localparam int test_cycles = 4 * half_frame + 400;
    localparam int watchdog_ns = 2 * test_cycles * 10;

    logic clk_12_288_mhz = 1'b0;
    logic reset;
    logic [`CORE_OUT_COLOR_WIDTH-1:0] game_red;
    logic [`CORE_OUT_COLOR_WIDTH-1:0] game_green;
    logic [`CORE_OUT_COLOR_WIDTH-1:0] game_blue;
    logic game_hsync;
    logic game_vsync;
    logic game_hblank;
    logic game_vblank;
    logic game_ce_pix;
    logic signed [`CORE_OUT_SOUND_WIDTH-1:0] game_sound;
    logic [$bits(rgb_word_u)-1:0] video_rgb;
    logic video_de;
    logic video_skip;
    logic video_hs;
    logic video_vs;
    logic audio_dac;
    logic audio_lrck;
    int cycle_count = 0;

    core_out_top uut (
        .clk_12_288_mhz (clk_12_288_mhz),
        .reset          (reset),
        .game_red       (game_red),
        .game_green     (game_green),
        .game_blue      (game_blue),
        .game_hsync     (game_hsync),
        .game_vsync     (game_vsync),
        .game_hblank    (game_hblank),
        .game_vblank    (game_vblank),
        .game_ce_pix    (game_ce_pix),
        .game_sound     (game_sound),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_skip     (video_skip),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .audio_dac      (audio_dac),
        .audio_lrck     (audio_lrck)
    );

    always #5 clk_12_288_mhz = ~clk_12_288_mhz;

    always @(posedge clk_12_288_mhz) begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // error handling and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic report_mismatch(input string what);
        fail_run($sformatf("Mismatch at time %0t: %s", $time, what));
    endtask

    task automatic check_rgb(input rgb_word_u actual, input rgb_word_u expected,
                             input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s rgb %h, expected %h", what, actual.bus, expected.bus));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic check_serial_bit(input logic actual, input logic expected, input int slot);
        if (actual !== expected) begin
            report_mismatch($sformatf("audio_dac slot %0d is %b, expected %b",
                                      slot, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic check_idle_outputs(input string when);
        check_rgb(video_rgb, '0, when);
        check_flag(video_de, 1'b0, {"video_de ", when});
        check_flag(video_skip, 1'b0, {"video_skip ", when});
        check_flag(video_hs, 1'b0, {"video_hs ", when});
        check_flag(video_vs, 1'b0, {"video_vs ", when});
        check_flag(audio_dac, 1'b0, {"audio_dac ", when});
        check_flag(audio_lrck, 1'b0, {"audio_lrck ", when});
    endtask

    task automatic test_reset_state;
        repeat (3) @(posedge clk_12_288_mhz);
        @(negedge clk_12_288_mhz);
        reset = 1'b0;
        check_idle_outputs("at reset release");
        // blanked idle inputs keep the outputs quiet
        repeat (2) @(negedge clk_12_288_mhz);
        check_idle_outputs("after reset");
    endtask

    task automatic test_pixel_expansion;
        logic [31:0] rnd;
        rgb_word_u expected;
        rgb_word_u previous;
        previous = '0;
        game_hblank = 1'b0;
        game_vblank = 1'b0;
        for (int i = 0; i < 16; i++) begin
            rnd = $urandom;
            game_red    = rnd[3:0];
            game_green  = rnd[7:4];
            game_blue   = rnd[11:8];
            game_ce_pix = rnd[12];
            expected.channels.red   = {rnd[3:0], 4'h0};
            expected.channels.green = {rnd[7:4], 4'h0};
            expected.channels.blue  = {rnd[11:8], 4'h0};
            // one cycle in the previous pixel is still on the outputs
            @(negedge clk_12_288_mhz);
            check_rgb(video_rgb, previous, $sformatf("pixel %0d after one cycle", i));
            check_flag(video_de, i > 0, $sformatf("video_de pixel %0d after one cycle", i));
            @(negedge clk_12_288_mhz);
            check_rgb(video_rgb, expected, $sformatf("pixel %0d", i));
            check_flag(video_de, 1'b1, $sformatf("video_de pixel %0d", i));
            check_flag(video_skip, ~rnd[12], $sformatf("video_skip pixel %0d", i));
            previous = expected;
        end
    endtask

    task automatic test_blanking;
        logic [31:0] rnd;
        for (int i = 1; i < 4; i++) begin
            rnd = $urandom;
            game_hblank = i[0];
            game_vblank = i[1];
            game_red    = rnd[3:0];
            game_green  = rnd[7:4];
            game_blue   = rnd[11:8];
            game_ce_pix = rnd[12];
            repeat (2) @(negedge clk_12_288_mhz);
            check_rgb(video_rgb, '0, $sformatf("blank case %0d", i));
            check_flag(video_de, 1'b0, $sformatf("video_de blank case %0d", i));
            check_flag(video_skip, 1'b0, $sformatf("video_skip blank case %0d", i));
        end
    endtask

    task automatic test_sync_edge(input logic vertical);
        logic pulse;
        logic other;
        string name;
        name = vertical ? "video_vs" : "video_hs";
        // high to low gives a single pulse three cycles later
        if (vertical) game_vsync = 1'b0;
        else game_hsync = 1'b0;
        for (int step = 1; step <= 6; step++) begin
            @(negedge clk_12_288_mhz);
            pulse = vertical ? video_vs : video_hs;
            other = vertical ? video_hs : video_vs;
            check_flag(pulse, step == 3, $sformatf("%s %0d cycles after fall", name, step));
            check_flag(other, 1'b0, $sformatf("other sync %0d cycles after fall", step));
        end
        // low to high gives nothing
        if (vertical) game_vsync = 1'b1;
        else game_hsync = 1'b1;
        for (int step = 1; step <= 6; step++) begin
            @(negedge clk_12_288_mhz);
            pulse = vertical ? video_vs : video_hs;
            check_flag(pulse, 1'b0, $sformatf("%s %0d cycles after rise", name, step));
        end
    endtask

    task automatic wait_lrck_toggle(output int at_cycle);
        logic start_level;
        logic found;
        int waited;
        start_level = audio_lrck;
        found = 1'b0;
        waited = 0;
        while (!found && waited < 2 * half_frame) begin
            @(negedge clk_12_288_mhz);
            waited++;
            if (audio_lrck !== start_level) found = 1'b1;
        end
        if (!found) fail_run("audio_lrck did not toggle within two audio half-frames");
        at_cycle = cycle_count;
    endtask

    // called just after an lrck change, next_sample goes in after the sample slots
    task automatic check_audio_slots(input logic signed [15:0] sample,
                                     input logic signed [15:0] next_sample);
        logic [15:0] remaining;
        logic expected;
        remaining = sample;
        @(negedge clk_12_288_mhz);
        for (int slot = 0; slot < `CORE_OUT_I2S_SLOT_BITS; slot++) begin
            if (slot > 0) repeat (`CORE_OUT_I2S_BIT_CYCLES) @(negedge clk_12_288_mhz);
            expected = 1'b0;
            if (slot >= 1 && slot <= 16) begin
                expected = remaining[15];
                remaining = {remaining[14:0], 1'b0};
            end
            check_serial_bit(audio_dac, expected, slot);
            if (slot == 16) game_sound = next_sample;
        end
    endtask

    task automatic test_audio_frames;
        logic [31:0] rnd;
        logic signed [15:0] first_sample;
        logic signed [15:0] second_sample;
        int first_toggle;
        int second_toggle;
        rnd = $urandom;
        first_sample = rnd[15:0];
        second_sample = rnd[31:16];
        game_sound = first_sample;
        // let the capture register take the sample before watching lrck
        @(negedge clk_12_288_mhz);
        wait_lrck_toggle(first_toggle);
        check_audio_slots(first_sample, second_sample);
        wait_lrck_toggle(second_toggle);
        if (second_toggle - first_toggle != half_frame) begin
            report_mismatch($sformatf("audio_lrck toggled %0d cycles apart, expected %0d",
                                      second_toggle - first_toggle, half_frame));
        end
        check_audio_slots(second_sample, second_sample);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset       = 1'b1;
        game_red    = '0;
        game_green  = '0;
        game_blue   = '0;
        game_hsync  = 1'b1;
        game_vsync  = 1'b1;
        game_hblank = 1'b1;
        game_vblank = 1'b1;
        game_ce_pix = 1'b0;
        game_sound  = '0;
        void'($urandom(32'hd4cc_34c6));
        test_reset_state();
        test_pixel_expansion();
        test_blanking();
        test_sync_edge(1'b0);
        test_sync_edge(1'b1);
        test_audio_frames();
        $display("TB PASSED");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        fail_run("Watchdog timeout: the tests did not finish in the allowed time");
    end

endmodule

`default_nettype wire

// File: hw/core_out_config.svh
/*
 * build-time sizes for the core output adapter
 * color and sound widths follow the game core and are not meant to vary
 * bit cycles must stay a power of two for the serializer bit counter
 */

`ifndef CORE_OUT_CONFIG_SVH
`define CORE_OUT_CONFIG_SVH

// game side
`define CORE_OUT_COLOR_WIDTH 4
`define CORE_OUT_SOUND_WIDTH 16

// serial audio framing
`define CORE_OUT_I2S_SLOT_BITS 32

// clocks per serial bit, power of two
`define CORE_OUT_I2S_BIT_CYCLES 4

`endif

// File: hw/core_out_pkg.sv
/*
 * types shared by the output adapter
 * the rgb word is built per channel and leaves as one flat 24-bit bus
 */

`default_nettype none

package core_out_pkg;

    // scaler video word, red in the top byte
    typedef union packed {
        struct packed {
            logic [7:0] red;
            logic [7:0] green;
            logic [7:0] blue;
        } channels;
        logic [23:0] bus;
    } rgb_word_u;

endpackage

`default_nettype wire

// File: hw/core_out_top.sv
/*
 * output adapter of the arcade core, single clock domain
 * video outputs lag the game inputs by two cycles, sync pulses by three
 * audio is serial with lrck, no master clock output
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_out_config.svh"

module core_out_top (
    input  logic clk_12_288_mhz,
    input  logic reset,

    // game side
    input  logic [`CORE_OUT_COLOR_WIDTH-1:0] game_red,
    input  logic [`CORE_OUT_COLOR_WIDTH-1:0] game_green,
    input  logic [`CORE_OUT_COLOR_WIDTH-1:0] game_blue,
    input  logic game_hsync,
    input  logic game_vsync,
    input  logic game_hblank,
    input  logic game_vblank,
    input  logic game_ce_pix,
    input  logic signed [`CORE_OUT_SOUND_WIDTH-1:0] game_sound,

    // scaler side
    output logic [$bits(core_out_pkg::rgb_word_u)-1:0] video_rgb,
    output logic video_de,
    output logic video_skip,
    output logic video_hs,
    output logic video_vs,
    output logic audio_dac,
    output logic audio_lrck
);

    import core_out_pkg::*;

    game_video_if video_link ();

    logic signed [`CORE_OUT_SOUND_WIDTH-1:0] captured_sound;
    rgb_word_u formatted_rgb;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    game_signal_capture u_capture (
        .clk_12_288_mhz (clk_12_288_mhz),
        .reset          (reset),
        .game_red       (game_red),
        .game_green     (game_green),
        .game_blue      (game_blue),
        .game_hsync     (game_hsync),
        .game_vsync     (game_vsync),
        .game_hblank    (game_hblank),
        .game_vblank    (game_vblank),
        .game_ce_pix    (game_ce_pix),
        .game_sound     (game_sound),
        .video          (video_link.source),
        .sound          (captured_sound)
    );

    //////////////////////////////////////////////////////////////////////
    // video and audio outputs
    //////////////////////////////////////////////////////////////////////

    video_formatter u_formatter (
        .clk_12_288_mhz (clk_12_288_mhz),
        .reset          (reset),
        .video          (video_link.sink),
        .rgb            (formatted_rgb),
        .de             (video_de),
        .skip           (video_skip),
        .hs             (video_hs),
        .vs             (video_vs)
    );

    i2s_serializer u_serializer (
        .clk_12_288_mhz (clk_12_288_mhz),
        .reset          (reset),
        .sample         (captured_sound),
        .dac            (audio_dac),
        .lrck           (audio_lrck)
    );

    // flat bus view to the scaler
    assign video_rgb = formatted_rgb.bus;

endmodule

`default_nettype wire

// File: hw/game_signal_capture.sv
/*
 * input boundary registers for game video and sound
 * syncs are active low, a fall flag shows one cycle after the captured low
 * reset holds blanks and syncs high so no false sync edge appears
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_out_config.svh"

module game_signal_capture (
    input  logic clk_12_288_mhz,
    input  logic reset,

    input  logic [`CORE_OUT_COLOR_WIDTH-1:0] game_red,
    input  logic [`CORE_OUT_COLOR_WIDTH-1:0] game_green,
    input  logic [`CORE_OUT_COLOR_WIDTH-1:0] game_blue,
    input  logic game_hsync,
    input  logic game_vsync,
    input  logic game_hblank,
    input  logic game_vblank,
    input  logic game_ce_pix,
    input  logic signed [`CORE_OUT_SOUND_WIDTH-1:0] game_sound,

    game_video_if.source video,
    output logic signed [`CORE_OUT_SOUND_WIDTH-1:0] sound
);

    // captured syncs and their previous values
    logic hsync_q;
    logic vsync_q;
    logic hsync_d;
    logic vsync_d;

    //////////////////////////////////////////////////////////////////////
    // capture registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_12_288_mhz) begin
        if (reset) begin
            video.red    <= '0;
            video.green  <= '0;
            video.blue   <= '0;
            video.hblank <= 1'b1;
            video.vblank <= 1'b1;
            video.ce_pix <= 1'b0;
            sound        <= '0;
            hsync_q      <= 1'b1;
            vsync_q      <= 1'b1;
            hsync_d      <= 1'b1;
            vsync_d      <= 1'b1;
        end else begin
            video.red    <= game_red;
            video.green  <= game_green;
            video.blue   <= game_blue;
            video.hblank <= game_hblank;
            video.vblank <= game_vblank;
            video.ce_pix <= game_ce_pix;
            sound        <= game_sound;
            hsync_q      <= game_hsync;
            vsync_q      <= game_vsync;
            hsync_d      <= hsync_q;
            vsync_d      <= vsync_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // falling sync detect
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_12_288_mhz) begin
        if (reset) begin
            video.hs_fall <= 1'b0;
            video.vs_fall <= 1'b0;
        end else begin
            // high before, low now
            video.hs_fall <= hsync_d & ~hsync_q;
            video.vs_fall <= vsync_d & ~vsync_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/game_video_if.sv
/*
 * captured game video between the capture stage and the formatter
 * every signal is a registered level, the fall flags last one cycle
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_out_config.svh"

interface game_video_if;

    logic [`CORE_OUT_COLOR_WIDTH-1:0] red;
    logic [`CORE_OUT_COLOR_WIDTH-1:0] green;
    logic [`CORE_OUT_COLOR_WIDTH-1:0] blue;
    logic hblank;
    logic vblank;
    logic ce_pix;

    // one-cycle marks of a falling sync
    logic hs_fall;
    logic vs_fall;

    modport source (output red, green, blue, hblank, vblank, ce_pix, hs_fall, vs_fall);

    modport sink (input red, green, blue, hblank, vblank, ce_pix, hs_fall, vs_fall);

endinterface

`default_nettype wire

// File: hw/i2s_serializer.sv
/*
 * serial audio out, one sample per half-frame of 32 slots
 * slot 0 is zero, then the sample msb first, then zero fill
 * the same sample goes to both channels, lrck toggles every half-frame
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_out_config.svh"

module i2s_serializer (
    input  logic clk_12_288_mhz,
    input  logic reset,

    input  logic signed [`CORE_OUT_SOUND_WIDTH-1:0] sample,

    output logic dac,
    output logic lrck
);

    localparam int slot_bits   = `CORE_OUT_I2S_SLOT_BITS;
    localparam int bit_cycles  = `CORE_OUT_I2S_BIT_CYCLES;
    localparam int sound_width = `CORE_OUT_SOUND_WIDTH;
    localparam int count_width = $clog2(slot_bits * bit_cycles);
    localparam int phase_width = $clog2(bit_cycles);
    localparam int fill_bits   = slot_bits - 1 - sound_width;

    logic [count_width-1:0] counter;
    logic [slot_bits-1:0] shifter;
    logic frame_edge;
    logic bit_edge;

    // counter wraps to zero on this edge
    assign frame_edge = &counter;

    // last cycle of a serial bit
    assign bit_edge = &counter[phase_width-1:0];

    //////////////////////////////////////////////////////////////////////
    // bit timing and shift register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_12_288_mhz) begin
        if (reset) begin
            counter <= '0;
            shifter <= '0;
            lrck    <= 1'b0;
        end else begin
            counter <= counter + 1'b1;
            if (frame_edge) begin
                // new half-frame, slot word loaded
                shifter <= {1'b0, sample, {fill_bits{1'b0}}};
                lrck    <= ~lrck;
            end else if (bit_edge) begin
                shifter <= {shifter[slot_bits-2:0], 1'b0};
            end
        end
    end

    assign dac = shifter[slot_bits-1];

endmodule

`default_nettype wire

// File: hw/video_formatter.sv
/*
 * scaler video from captured game video, all outputs registered
 * color nibbles are padded with low zero bits, not replicated
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_out_config.svh"

module video_formatter (
    input  logic clk_12_288_mhz,
    input  logic reset,

    game_video_if.sink video,

    output core_out_pkg::rgb_word_u rgb,
    output logic de,
    output logic skip,
    output logic hs,
    output logic vs
);

    import core_out_pkg::*;

    localparam int pad_bits = 8 - `CORE_OUT_COLOR_WIDTH;

    logic de_next;
    rgb_word_u rgb_next;

    // active only with both blanks low
    assign de_next = ~(video.hblank | video.vblank);

    always_comb begin
        rgb_next = '0;
        if (de_next) begin
            rgb_next.channels.red   = {video.red, {pad_bits{1'b0}}};
            rgb_next.channels.green = {video.green, {pad_bits{1'b0}}};
            rgb_next.channels.blue  = {video.blue, {pad_bits{1'b0}}};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_12_288_mhz) begin
        if (reset) begin
            rgb  <= '0;
            de   <= 1'b0;
            skip <= 1'b0;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else begin
            rgb  <= rgb_next;
            de   <= de_next;
            // visible cycle without a new pixel
            skip <= de_next & ~video.ce_pix;
            hs   <= video.hs_fall;
            vs   <= video.vs_fall;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/core_out_pkg.sv
hw/game_video_if.sv
hw/game_signal_capture.sv
hw/video_formatter.sv
hw/i2s_serializer.sv
hw/core_out_top.sv
bench/core_out_assert.sv
bench/core_out_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core output testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module core_out_tb \
    -f project.f \
    -Mdir obj_dir

# a fatal stop returns nonzero, the search below decides the result
sim_output="$(./obj_dir/Vcore_out_tb 2>&1)" || true
echo "$sim_output"

if grep -qx "TB PASSED" <<< "$sim_output"; then
    exit 0
fi
echo "simulation did not pass" >&2
exit 1
